// File: source/mos_irq_pkg.sv
package mos_irq_pkg;

  // vector pairs, low byte address of each
  localparam logic [15:0] vec_nmi = 16'hfffa;
  localparam logic [15:0] vec_res = 16'hfffc;
  localparam logic [15:0] vec_irq = 16'hfffe;  // shared by irq and brk

  localparam logic [7:0] stack_page = 8'h01;  // stack lives in page one

  localparam logic [7:0] s_reset   = 8'hfd;
  localparam logic [7:0] psr_reset = 8'h34;  // i set, b and bit 5 high

  // bus controller handshake states
  localparam logic [1:0] bc_idle     = 2'd0;
  localparam logic [1:0] bc_wait_ack = 2'd1;  // req high, waiting for ack
  localparam logic [1:0] bc_wait_rel = 2'd2;  // req dropped, waiting for ack low

  // status register, seen as a byte or as flags
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic n;
      logic v;
      logic one;
      logic b;
      logic d;
      logic i;
      logic z;
      logic c;
    } f;
  } psr_t;

  typedef enum logic [2:0] {
    seq_idle,
    seq_push_pch,
    seq_push_pcl,
    seq_push_psr,
    seq_vec_lo,
    seq_vec_hi
  } seq_state_t;

  typedef enum logic [1:0] {
    exc_res,
    exc_nmi,
    exc_irq,
    exc_brk
  } exc_kind_t;

endpackage

// File: source/mem_bus_if.sv
`timescale 1ns/1ps

// single access exchange between sequencer and bus controller
interface mem_bus_if;
  logic        start;  // one cycle, only when nothing is outstanding
  logic        write;
  logic [15:0] addr;
  logic [7:0]  wdata;
  logic [7:0]  rdata;  // valid while done is high
  logic        done;

  modport sequencer (
    output start,
    output write,
    output addr,
    output wdata,
    input  rdata,
    input  done
  );

  modport controller (
    input  start,
    input  write,
    input  addr,
    input  wdata,
    output rdata,
    output done
  );
endinterface

// File: source/regfile_bus_if.sv
`timescale 1ns/1ps

interface regfile_bus_if;
  import mos_irq_pkg::*;

  logic [15:0] pc;
  logic [7:0]  s;
  psr_t        psr;

  // update strobes, each takes effect at the next edge
  logic        set_pcl;
  logic        set_pch;
  logic        dec_s;
  logic        set_i;
  logic [7:0]  data;  // byte for set_pcl / set_pch

  modport sequencer (
    input  pc,
    input  s,
    input  psr,
    output set_pcl,
    output set_pch,
    output dec_s,
    output set_i,
    output data
  );

  modport register (
    output pc,
    output s,
    output psr,
    input  set_pcl,
    input  set_pch,
    input  dec_s,
    input  set_i,
    input  data
  );
endinterface

// File: source/interrupt_sequencer.sv
`timescale 1ns/1ps

module interrupt_sequencer (
  input  logic             clk,
  input  logic             rst_x,
  input  logic             irq_x,
  input  logic             nmi_x,
  input  logic             brk,
  output logic             busy,
  output logic             seq_done,
  mem_bus_if.sequencer     mem,
  regfile_bus_if.sequencer rf
);
  import mos_irq_pkg::*;

  seq_state_t  state;
  exc_kind_t   kind;       // exception being served
  exc_kind_t   next_kind;
  logic        accept;
  logic        res_pend;   // reset vector still to be fetched
  logic        nmi_q;
  logic        nmi_fall;
  logic        nmi_pend;
  logic        brk_pend;
  logic        start_q;
  logic        done_q;
  logic        is_write;
  logic [15:0] vec_base;
  psr_t        push_psr;

  assign nmi_fall = nmi_q & ~nmi_x;

  // acceptance only in idle: reset, then nmi, brk, irq
  always_comb begin
    accept    = 1'b0;
    next_kind = exc_res;
    if (state == seq_idle) begin
      if (res_pend) begin
        accept = 1'b1;
      end else if (nmi_pend || nmi_fall) begin
        accept    = 1'b1;
        next_kind = exc_nmi;
      end else if (brk_pend || brk) begin
        accept    = 1'b1;
        next_kind = exc_brk;
      end else if (nmi_x && !irq_x && !rf.psr.f.i) begin
        accept    = 1'b1;
        next_kind = exc_irq;
      end
    end
  end

  always_comb begin
    case (kind)
      exc_nmi: vec_base = vec_nmi;
      exc_res: vec_base = vec_res;
      default: vec_base = vec_irq;
    endcase
  end

  // pushed status carries b only for brk
  always_comb begin
    push_psr     = rf.psr;
    push_psr.f.b = (kind == exc_brk);
  end

  assign is_write = (state == seq_push_pch) || (state == seq_push_pcl) ||
                    (state == seq_push_psr);

  assign mem.start = start_q;
  assign mem.write = is_write;
  assign mem.addr  = is_write ? {stack_page, rf.s}
                              : {vec_base[15:1], state == seq_vec_hi};

  always_comb begin
    case (state)
      seq_push_pch: mem.wdata = rf.pc[15:8];
      seq_push_pcl: mem.wdata = rf.pc[7:0];
      seq_push_psr: mem.wdata = push_psr.raw;
      default:      mem.wdata = 8'h00;
    endcase
  end

  // register file updates ride on the done pulse
  assign rf.dec_s   = mem.done & is_write;
  assign rf.set_i   = mem.done & (state == seq_push_psr);
  assign rf.set_pcl = mem.done & (state == seq_vec_lo);
  assign rf.set_pch = mem.done & (state == seq_vec_hi);
  assign rf.data    = mem.rdata;

  assign busy     = (state != seq_idle);
  assign seq_done = done_q;

  always_ff @(posedge clk or negedge rst_x) begin
    if (!rst_x) begin
      state    <= seq_idle;
      kind     <= exc_res;
      res_pend <= 1'b1;
      nmi_q    <= 1'b1;
      nmi_pend <= 1'b0;
      brk_pend <= 1'b0;
      start_q  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      nmi_q   <= nmi_x;
      start_q <= 1'b0;
      done_q  <= 1'b0;

      if (accept && next_kind == exc_nmi) begin
        nmi_pend <= 1'b0;
      end else if (nmi_fall) begin
        nmi_pend <= 1'b1;
      end
      if (accept && next_kind == exc_brk) begin
        brk_pend <= 1'b0;
      end else if (brk) begin
        brk_pend <= 1'b1;  // held until idle again
      end
      if (accept && next_kind == exc_res) begin
        res_pend <= 1'b0;
      end

      case (state)
        seq_idle: begin
          if (accept) begin
            kind    <= next_kind;
            start_q <= 1'b1;
            state   <= (next_kind == exc_res) ? seq_vec_lo : seq_push_pch;
          end
        end
        seq_push_pch: begin
          if (mem.done) begin
            state   <= seq_push_pcl;
            start_q <= 1'b1;
          end
        end
        seq_push_pcl: begin
          if (mem.done) begin
            state   <= seq_push_psr;
            start_q <= 1'b1;
          end
        end
        seq_push_psr: begin
          if (mem.done) begin
            state   <= seq_vec_lo;
            start_q <= 1'b1;
          end
        end
        seq_vec_lo: begin
          if (mem.done) begin
            state   <= seq_vec_hi;
            start_q <= 1'b1;
          end
        end
        seq_vec_hi: begin
          if (mem.done) begin
            state  <= seq_idle;
            done_q <= 1'b1;  // pc is final in the same cycle
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end
endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic           clk,
  input  logic           rst_x,
  input  logic           load,
  input  logic [15:0]    load_pc,
  input  logic [7:0]     load_s,
  input  logic [7:0]     load_psr,
  regfile_bus_if.register rf,
  output logic [15:0]    pc,
  output logic [7:0]     s,
  output logic [7:0]     psr
);
  import mos_irq_pkg::*;

  logic [15:0] pc_q;
  logic [7:0]  s_q;
  psr_t        psr_q;

  always_ff @(posedge clk or negedge rst_x) begin
    if (!rst_x) begin
      pc_q      <= 16'h0000;
      s_q       <= s_reset;
      psr_q.raw <= psr_reset;
    end else if (load) begin
      // core load wins over sequencer strobes
      pc_q      <= load_pc;
      s_q       <= load_s;
      psr_q.raw <= load_psr;
    end else begin
      if (rf.set_pcl) begin
        pc_q[7:0] <= rf.data;
      end
      if (rf.set_pch) begin
        pc_q[15:8] <= rf.data;
      end
      if (rf.dec_s) begin
        s_q <= s_q - 8'd1;  // wraps inside page one
      end
      if (rf.set_i) begin
        psr_q.f.i <= 1'b1;
      end
    end
  end

  assign rf.pc  = pc_q;
  assign rf.s   = s_q;
  assign rf.psr = psr_q;

  assign pc  = pc_q;
  assign s   = s_q;
  assign psr = psr_q.raw;
endmodule

// File: source/bus_controller.sv
`timescale 1ns/1ps

module bus_controller (
  input  logic          clk,
  input  logic          rst_x,
  mem_bus_if.controller mem,
  output logic          mem_req,
  output logic          mem_we,
  output logic [15:0]   mem_addr,
  output logic [7:0]    mem_wdata,
  input  logic          mem_ack,
  input  logic [7:0]    mem_rdata
);
  import mos_irq_pkg::*;

  logic [1:0] state;
  logic [7:0] rdata_q;
  logic       done_q;

  // four-phase handshake: req up, ack up, req down, ack down
  always_ff @(posedge clk or negedge rst_x) begin
    if (!rst_x) begin
      state   <= bc_idle;
      mem_req <= 1'b0;
      mem_we  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        bc_idle: begin
          if (mem.start) begin
            mem_req <= 1'b1;
            mem_we  <= mem.write;
            state   <= bc_wait_ack;
          end
        end
        bc_wait_ack: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= bc_wait_rel;
          end
        end
        bc_wait_rel: begin
          if (!mem_ack) begin
            mem_we <= 1'b0;
            done_q <= 1'b1;
            state  <= bc_idle;
          end
        end
        default: state <= bc_idle;
      endcase
    end
  end

  // address and write data held stable for the whole transfer
  always_ff @(posedge clk) begin
    if (state == bc_idle && mem.start) begin
      mem_addr  <= mem.addr;
      mem_wdata <= mem.wdata;
    end
    if (state == bc_wait_ack && mem_ack) begin
      rdata_q <= mem_rdata;  // sampled as ack rises
    end
  end

  assign mem.rdata = rdata_q;
  assign mem.done  = done_q;
endmodule

// File: source/irq_subsystem_top.sv
`timescale 1ns/1ps

module irq_subsystem_top (
  input  logic        clk,
  input  logic        rst_x,
  input  logic        irq_x,
  input  logic        nmi_x,
  input  logic        brk,
  input  logic        load,
  input  logic [15:0] load_pc,
  input  logic [7:0]  load_s,
  input  logic [7:0]  load_psr,
  output logic        mem_req,
  output logic        mem_we,
  output logic [15:0] mem_addr,
  output logic [7:0]  mem_wdata,
  input  logic        mem_ack,
  input  logic [7:0]  mem_rdata,
  output logic [15:0] pc,
  output logic [7:0]  s,
  output logic [7:0]  psr,
  output logic        busy,
  output logic        seq_done
);

  mem_bus_if     mem_bus ();
  regfile_bus_if rf_bus ();

  interrupt_sequencer u_seq (
    .clk      (clk),
    .rst_x    (rst_x),
    .irq_x    (irq_x),
    .nmi_x    (nmi_x),
    .brk      (brk),
    .busy     (busy),
    .seq_done (seq_done),
    .mem      (mem_bus.sequencer),
    .rf       (rf_bus.sequencer)
  );

  register_file u_rf (
    .clk      (clk),
    .rst_x    (rst_x),
    .load     (load),
    .load_pc  (load_pc),
    .load_s   (load_s),
    .load_psr (load_psr),
    .rf       (rf_bus.register),
    .pc       (pc),
    .s        (s),
    .psr      (psr)
  );

  bus_controller u_bus (
    .clk       (clk),
    .rst_x     (rst_x),
    .mem       (mem_bus.controller),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );
endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_x
);
  localparam int half_period = 50;  // 100 ns clock

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // reset held over the first four rising edges
  initial begin
    rst_x = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_x = 1'b1;
  end
endmodule

// File: dv/irq_tb.sv
`timescale 1ns/1ps

module irq_tb;
  import mos_irq_pkg::*;

  localparam int num_seq = 26;  // exception sequences over all tests
  localparam int watchdog_ns = num_seq * 5 * 8 * 100 + 40000;
  localparam logic [31:0] seed = 32'h8f89_f738;

  // what one exception entry should leave behind
  typedef struct packed {
    logic [1:0]       nwr;
    logic [2:0][15:0] wa;
    logic [2:0][7:0]  wd;
    logic [15:0]      pc;
    logic [7:0]       s;
    logic [7:0]       psr;
  } result_t;

  logic        clk;
  logic        rst_x;
  logic        irq_x;
  logic        nmi_x;
  logic        brk;
  logic        load;
  logic [15:0] load_pc;
  logic [7:0]  load_s;
  logic [7:0]  load_psr;
  logic        mem_req;
  logic        mem_we;
  logic [15:0] mem_addr;
  logic [7:0]  mem_wdata;
  logic        mem_ack;
  logic [7:0]  mem_rdata;
  logic [15:0] pc;
  logic [7:0]  s;
  logic [7:0]  psr;
  logic        busy;
  logic        seq_done;

  logic [7:0]  mem [0:65535];
  logic [15:0] wr_addr_q [$];  // writes seen since the last seq_done
  logic [7:0]  wr_data_q [$];
  result_t     exp_q [$];
  logic [31:0] lat_state = seed;
  logic [31:0] stim_state = seed;
  int          errors = 0;
  int          err_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          checked_count = 0;
  int          seq_target = 0;

  tb_clock_gen u_clk (
    .clk   (clk),
    .rst_x (rst_x)
  );

  irq_subsystem_top UUT (
    .clk       (clk),
    .rst_x     (rst_x),
    .irq_x     (irq_x),
    .nmi_x     (nmi_x),
    .brk       (brk),
    .load      (load),
    .load_pc   (load_pc),
    .load_s    (load_s),
    .load_psr  (load_psr),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .s         (s),
    .psr       (psr),
    .busy      (busy),
    .seq_done  (seq_done)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_stim();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  // three pushes below S before the vector pair is read
  function automatic result_t exception_result(input exc_kind_t kind,
                                               input logic [15:0] pc0,
                                               input logic [7:0] s0,
                                               input logic [7:0] psr0);
    result_t     r;
    logic [15:0] vec;
    r = '0;
    case (kind)
      exc_nmi: vec = vec_nmi;
      exc_res: vec = vec_res;
      default: vec = vec_irq;
    endcase
    r.pc = {mem[vec + 16'd1], mem[vec]};
    if (kind == exc_res) begin  // reset pushes nothing
      r.s   = s0;
      r.psr = psr0;
    end else begin
      r.nwr   = 2'd3;
      r.wa[0] = {8'h01, s0};
      r.wa[1] = {8'h01, s0 - 8'd1};
      r.wa[2] = {8'h01, s0 - 8'd2};  // wraps inside page one
      r.wd[0] = pc0[15:8];
      r.wd[1] = pc0[7:0];
      r.wd[2] = (kind == exc_brk) ? (psr0 | 8'h10) : (psr0 & 8'hef);
      r.s     = s0 - 8'd3;
      r.psr   = psr0 | 8'h04;  // i set on entry
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic set_vector(input logic [15:0] addr, input logic [15:0] value);
    mem[addr]         = value[7:0];
    mem[addr + 16'd1] = value[15:8];
  endtask

  task automatic load_regs(input logic [15:0] new_pc, input logic [7:0] new_s,
                           input logic [7:0] new_psr);
    load     = 1'b1;
    load_pc  = new_pc;
    load_s   = new_s;
    load_psr = new_psr;
    step();
    load = 1'b0;
  endtask

  task automatic wait_checks(input int n);
    int waited;
    waited = 0;
    seq_target = seq_target + n;
    while (checked_count < seq_target && waited < n * 60) begin
      @(negedge clk);
      waited++;
    end
    check_cond(checked_count >= seq_target, "timeout: the DUT gave no seq_done in time");
    step();
  endtask

  // no new sequence may start and pc must hold
  task automatic expect_idle(input int cycles);
    logic [15:0] pc_hold;
    pc_hold = pc;
    repeat (cycles) begin
      @(negedge clk);
      check_value("busy", busy, 1'b0);
      check_value("pc", pc, pc_hold);
    end
    step();
  endtask

  task automatic run_exception(input exc_kind_t kind, input logic [15:0] new_pc,
                               input logic [7:0] new_s, input logic [7:0] new_psr);
    load_regs(new_pc, new_s, new_psr);
    exp_q.push_back(exception_result(kind, new_pc, new_s, new_psr));
    case (kind)
      exc_nmi: nmi_x = 1'b0;
      exc_irq: irq_x = 1'b0;
      default: begin
        brk = 1'b1;
        step();
        brk = 1'b0;
      end
    endcase
    wait_checks(1);
  endtask

  task automatic release_lines();
    nmi_x = 1'b1;
    irq_x = 1'b1;
  endtask

  task automatic begin_test();
    err_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_at_start);
    end
  endtask

  // memory side of the four-phase handshake with random ack latency
  initial begin : memory_model
    int wait_cycles;
    forever begin
      step();
      if (rst_x && mem_req && !mem_ack) begin
        check_value("busy", busy, 1'b1);  // an access only runs inside a sequence
        lat_state   = xorshift32(lat_state);
        wait_cycles = int'(lat_state[1:0]);
        repeat (wait_cycles) step();
        if (mem_we) begin
          mem[mem_addr] = mem_wdata;
          wr_addr_q.push_back(mem_addr);
          wr_data_q.push_back(mem_wdata);
        end else begin
          mem_rdata = mem[mem_addr];
        end
        mem_ack = 1'b1;
        step();
        while (mem_req) step();
        mem_ack = 1'b0;
      end
    end
  end

  initial begin : compare_results
    result_t r;
    forever begin
      step();
      if (rst_x && seq_done) begin
        check_cond(exp_q.size() > 0, "seq_done pulsed with no exception outstanding");
        if (exp_q.size() > 0) begin
          r = exp_q.pop_front();
          check_value("write count", wr_addr_q.size(), r.nwr);
          for (int i = 0; i < r.nwr && i < wr_addr_q.size(); i++) begin
            check_value("mem_addr", wr_addr_q[i], r.wa[i]);
            check_value("mem_wdata", wr_data_q[i], r.wd[i]);
          end
          check_value("pc", pc, r.pc);
          check_value("s", s, r.s);
          check_value("psr", psr, r.psr);
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        checked_count++;
      end
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("timeout: run did not finish within %0d ns", watchdog_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : run_tests
    result_t     r1;
    result_t     r2;
    exc_kind_t   kind;
    logic [31:0] rnd;
    logic [7:0]  rpsr;
    irq_x     = 1'b1;
    nmi_x     = 1'b1;
    brk       = 1'b0;
    load      = 1'b0;
    load_pc   = 16'h0000;
    load_s    = 8'h00;
    load_psr  = 8'h00;
    mem_ack   = 1'b0;
    mem_rdata = 8'h00;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = a[15:8] ^ a[7:0] ^ 8'ha5;
    end
    set_vector(vec_nmi, 16'h8abc);
    set_vector(vec_res, 16'hc012);
    set_vector(vec_irq, 16'hd345);

    begin_test();
    exp_q.push_back(exception_result(exc_res, 16'h0000, 8'hfd, 8'h34));
    wait_checks(1);
    end_test("1 reset vector fetch");

    begin_test();
    run_exception(exc_brk, 16'h1234, 8'hf0, 8'h21);
    end_test("2 brk entry");

    begin_test();
    run_exception(exc_irq, 16'habcd, 8'h80, 8'hc3);
    expect_idle(20);  // irq_x still low but masked by i
    release_lines();
    end_test("3 irq entry and masked irq");

    begin_test();
    run_exception(exc_nmi, 16'h5678, 8'h40, 8'h61);
    expect_idle(30);
    release_lines();
    end_test("4 nmi edge, held low");

    begin_test();
    load_regs(16'h0f0e, 8'h02, 8'h10);  // stack wraps across 0100
    r1 = exception_result(exc_nmi, 16'h0f0e, 8'h02, 8'h10);
    r2 = exception_result(exc_brk, r1.pc, r1.s, r1.psr);
    exp_q.push_back(r1);
    exp_q.push_back(r2);
    nmi_x = 1'b0;
    brk   = 1'b1;
    step();
    brk = 1'b0;
    wait_checks(2);
    release_lines();
    end_test("5 nmi before pending brk");

    begin_test();
    for (int n = 0; n < 20; n++) begin
      rnd = next_stim();
      set_vector(vec_nmi, rnd[15:0]);
      set_vector(vec_irq, rnd[31:16]);
      rnd  = next_stim();
      rpsr = rnd[7:0];
      case (rnd[31:8] % 3)
        0: kind = exc_nmi;
        1: kind = exc_irq;
        default: kind = exc_brk;
      endcase
      if (kind == exc_irq) begin
        rpsr[2] = 1'b0;
      end
      rnd = next_stim();
      run_exception(kind, rnd[15:0], rnd[23:16], rpsr);
      release_lines();
    end
    end_test("6 random exceptions");

    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end
endmodule

// File: files.f
source/mos_irq_pkg.sv
source/mem_bus_if.sv
source/regfile_bus_if.sv
source/interrupt_sequencer.sv
source/register_file.sv
source/bus_controller.sv
source/irq_subsystem_top.sv
dv/tb_clock_gen.sv
dv/irq_tb.sv

// File: Bender.yml
package:
  name: irq_subsystem

sources:
  - source/mos_irq_pkg.sv
  - source/mem_bus_if.sv
  - source/regfile_bus_if.sv
  - source/interrupt_sequencer.sv
  - source/register_file.sv
  - source/bus_controller.sv
  - source/irq_subsystem_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/irq_tb.sv
